// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  localparam int XLEN       = 32;      // Data and address width
  localparam int RAM_WORDS  = 2048;    // 8 KiB data RAM
  localparam int RAM_AW     = 11;      // Word index width
  localparam int LEDR_W     = 17;
  localparam int LEDG_W     = 8;
  localparam int SW_W       = 18;
  localparam int BTN_W      = 10;
  localparam int HEX_DIGITS = 8;
  localparam int SEG_W      = 7;       // Segments a..g, no dot

  // Address map, inclusive bounds
  localparam logic [XLEN-1:0] RAM_BASE  = 32'h0000_2000;
  localparam logic [XLEN-1:0] RAM_LAST  = 32'h0000_3FFF;
  localparam logic [XLEN-1:0] LEDR_BASE = 32'h0000_7000;
  localparam logic [XLEN-1:0] LEDR_LAST = 32'h0000_700F;
  localparam logic [XLEN-1:0] LEDG_BASE = 32'h0000_7010;
  localparam logic [XLEN-1:0] LEDG_LAST = 32'h0000_701F;
  localparam logic [XLEN-1:0] HEX_BASE  = 32'h0000_7020;
  localparam logic [XLEN-1:0] HEX_LAST  = 32'h0000_7027;  // Two words of four digits
  localparam logic [XLEN-1:0] SW_BASE   = 32'h0000_7800;
  localparam logic [XLEN-1:0] SW_LAST   = 32'h0000_780F;
  localparam logic [XLEN-1:0] BTN_BASE  = 32'h0000_7810;
  localparam logic [XLEN-1:0] BTN_LAST  = 32'h0000_781F;

  // RISC-V funct3 of loads and stores
  typedef enum logic [2:0] {
    OP_B  = 3'b000,
    OP_H  = 3'b001,
    OP_W  = 3'b010,
    OP_BU = 3'b100,
    OP_HU = 3'b101
  } mem_op_e;

  typedef enum logic [2:0] {
    REG_RAM, REG_LEDR, REG_LEDG, REG_HEX, REG_SW, REG_BTN, REG_NONE
  } region_e;

  typedef struct packed {
    logic            valid;
    logic            we;
    logic [XLEN-1:0] addr;
    mem_op_e         op;
    logic [XLEN-1:0] st_data;
  } lsu_req_t;

  typedef struct packed {
    logic              valid;
    logic              we;
    region_e           region;
    mem_op_e           op;
    logic [RAM_AW-1:0] word_idx;   // Relative to region base
    logic [1:0]        offset;
    logic [3:0]        byte_en;
    logic [XLEN-1:0]   lane_data;  // Store data moved up by offset
    logic              misaligned;
  } lsu_acc_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] data;
    logic            misaligned;
  } lsu_rsp_t;

  typedef struct packed {
    logic [SW_W-1:0]  sw;
    logic [BTN_W-1:0] btn;
  } board_in_t;

  typedef struct packed {
    logic [LEDR_W-1:0]                 ledr;
    logic [LEDG_W-1:0]                 ledg;
    logic [HEX_DIGITS-1:0][SEG_W-1:0] hex;
  } board_out_t;

endpackage

`default_nettype wire

// ==== rtl/lsu_access_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_access_decode
  import lsu_pkg::*;
(
  input  lsu_req_t i_req,
  output lsu_acc_t o_acc
);

  logic [XLEN-1:0] addr;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] rel_addr;
  region_e         region;
  logic [1:0]      offset;
  logic [3:0]      byte_en;
  logic            misaligned;

  function automatic logic in_range(input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] lo,
                                    input logic [XLEN-1:0] hi);
    return (a >= lo) && (a <= hi);
  endfunction

  assign addr   = i_req.addr;
  assign offset = addr[1:0];

  // The only place where addresses are compared
  always_comb begin
    region = REG_NONE;
    base   = '0;
    if (in_range(addr, RAM_BASE, RAM_LAST)) begin
      region = REG_RAM;
      base   = RAM_BASE;
    end else if (in_range(addr, LEDR_BASE, LEDR_LAST)) begin
      region = REG_LEDR;
      base   = LEDR_BASE;
    end else if (in_range(addr, LEDG_BASE, LEDG_LAST)) begin
      region = REG_LEDG;
      base   = LEDG_BASE;
    end else if (in_range(addr, HEX_BASE, HEX_LAST)) begin
      region = REG_HEX;
      base   = HEX_BASE;
    end else if (in_range(addr, SW_BASE, SW_LAST)) begin
      region = REG_SW;
      base   = SW_BASE;
    end else if (in_range(addr, BTN_BASE, BTN_LAST)) begin
      region = REG_BTN;
      base   = BTN_BASE;
    end
  end

  assign rel_addr = addr - base;

  always_comb begin
    misaligned = 1'b0;
    case (i_req.op)
      OP_B, OP_BU: byte_en = 4'b0001 << offset;
      OP_H, OP_HU: begin
        if (offset == 2'd3) begin
          byte_en    = 4'b0000;  // Would cross the word
          misaligned = 1'b1;
        end else begin
          byte_en = 4'b0011 << offset;
        end
      end
      OP_W:    byte_en = 4'b1111 << offset;  // Bytes offset..3 only
      default: byte_en = 4'b0000;
    endcase
  end

  always_comb begin
    o_acc.valid      = i_req.valid;
    o_acc.we         = i_req.we;
    o_acc.region     = region;
    o_acc.op         = i_req.op;
    o_acc.word_idx   = rel_addr[RAM_AW+1:2];
    o_acc.offset     = offset;
    o_acc.byte_en    = byte_en;
    o_acc.lane_data  = i_req.st_data << {offset, 3'b000};
    o_acc.misaligned = misaligned;
  end

endmodule

`default_nettype wire

// ==== rtl/lsu_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_data_ram
  import lsu_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst,
  input  lsu_acc_t        i_acc,
  output logic [XLEN-1:0] o_rd_word
);

  logic [XLEN-1:0] mem [RAM_WORDS];
  logic [XLEN-1:0] rd_q;
  logic            wr_en;

  assign wr_en = i_acc.valid && i_acc.we && (i_acc.region == REG_RAM);

  // Byte lanes written independently, no read-modify-write
  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (i_acc.byte_en[b]) begin
          mem[i_acc.word_idx][8*b +: 8] <= i_acc.lane_data[8*b +: 8];
        end
      end
    end
  end

  // Old contents on a same-edge write
  always_ff @(posedge i_clk) begin
    if (i_acc.valid) begin
      rd_q <= mem[i_acc.word_idx];
    end
  end

  assign o_rd_word = rd_q;

  // A misaligned store must reach the array with no lanes
  a_mis_no_lanes: assert property (
    @(posedge i_clk) disable iff (!i_rst)
    (wr_en && i_acc.misaligned) |-> (i_acc.byte_en == 4'b0000)
  ) else $error("misaligned RAM store carries byte enables");

endmodule

`default_nettype wire

// ==== rtl/lsu_board_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_board_io
  import lsu_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst,
  input  lsu_acc_t        i_acc,
  input  board_in_t       i_board,
  output logic [XLEN-1:0] o_rd_word,
  output board_out_t      o_board
);

  logic [LEDR_W-1:0]           ledr_q;
  logic [LEDG_W-1:0]           ledg_q;
  logic [HEX_DIGITS-1:0][7:0]  hex_q;     // Full byte kept per digit
  logic [XLEN-1:0]             rd_q;
  logic [XLEN-1:0]             rd_next;
  logic [XLEN-1:0]             hex_word;
  logic                        hex_sel;   // Upper or lower digit word
  logic                        st_en;

  // No lanes means nothing to write, covers misaligned too
  assign st_en   = i_acc.valid && i_acc.we && (|i_acc.byte_en);
  assign hex_sel = i_acc.word_idx[0];

  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      ledr_q <= '0;
      ledg_q <= '0;
      hex_q  <= '0;
    end else if (st_en) begin
      case (i_acc.region)
        REG_LEDR: ledr_q <= i_acc.lane_data[LEDR_W-1:0];  // Whole register
        REG_LEDG: ledg_q <= i_acc.lane_data[LEDG_W-1:0];
        REG_HEX: begin
          for (int b = 0; b < 4; b++) begin
            if (i_acc.byte_en[b]) begin
              hex_q[{hex_sel, 2'(b)}] <= i_acc.lane_data[8*b +: 8];
            end
          end
        end
        default: ;  // Switches and buttons are read only
      endcase
    end
  end

  always_comb begin
    if (hex_sel) begin
      hex_word = hex_q[HEX_DIGITS-1:HEX_DIGITS/2];
    end else begin
      hex_word = hex_q[HEX_DIGITS/2-1:0];
    end
  end

  always_comb begin
    case (i_acc.region)
      REG_LEDR: rd_next = XLEN'(ledr_q);
      REG_LEDG: rd_next = XLEN'(ledg_q);
      REG_HEX:  rd_next = hex_word;
      REG_SW:   rd_next = XLEN'(i_board.sw);   // Zero above bit 17
      REG_BTN:  rd_next = XLEN'(i_board.btn);
      default:  rd_next = '0;
    endcase
  end

  // Captured before this edge's store lands
  always_ff @(posedge i_clk) begin
    if (i_acc.valid) begin
      rd_q <= rd_next;
    end
  end

  assign o_rd_word = rd_q;

  always_comb begin
    o_board.ledr = ledr_q;
    o_board.ledg = ledg_q;
    for (int d = 0; d < HEX_DIGITS; d++) begin
      o_board.hex[d] = hex_q[d][SEG_W-1:0];  // Bit 7 stays internal
    end
  end

endmodule

`default_nettype wire

// ==== rtl/lsu_load_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_merge
  import lsu_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst,
  input  lsu_acc_t        i_acc,
  input  logic [XLEN-1:0] i_ram_word,
  input  logic [XLEN-1:0] i_io_word,
  output lsu_rsp_t        o_rsp
);

  logic            valid_q;
  logic            we_q;
  logic            mis_q;
  region_e         region_q;
  mem_op_e         op_q;
  logic [1:0]      offset_q;
  logic [XLEN-1:0] src_word;
  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] ld_data;

  // Descriptor lines up with the registered read words
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      mis_q    <= 1'b0;
      region_q <= REG_NONE;
      op_q     <= OP_W;
      offset_q <= 2'd0;
    end else begin
      valid_q  <= i_acc.valid;
      we_q     <= i_acc.we;
      mis_q    <= i_acc.misaligned;
      region_q <= i_acc.region;
      op_q     <= i_acc.op;
      offset_q <= i_acc.offset;
    end
  end

  always_comb begin
    case (region_q)
      REG_RAM:  src_word = i_ram_word;
      REG_NONE: src_word = '0;          // Unmapped reads as zero
      default:  src_word = i_io_word;
    endcase
  end

  assign shifted = src_word >> {offset_q, 3'b000};  // Zero fill from the top

  always_comb begin
    case (op_q)
      OP_B:    ld_data = {{24{shifted[7]}}, shifted[7:0]};
      OP_BU:   ld_data = {24'd0, shifted[7:0]};
      OP_H:    ld_data = {{16{shifted[15]}}, shifted[15:0]};
      OP_HU:   ld_data = {16'd0, shifted[15:0]};
      OP_W:    ld_data = shifted;
      default: ld_data = '0;
    endcase
  end

  always_comb begin
    o_rsp.valid      = valid_q;
    o_rsp.misaligned = valid_q && mis_q;
    if (!valid_q || we_q || mis_q) begin
      o_rsp.data = '0;  // Stores and misaligned give no data
    end else begin
      o_rsp.data = ld_data;
    end
  end

  // Only a halfword at byte offset 3 may come back flagged
  a_mis_is_half_off3: assert property (
    @(posedge i_clk) disable iff (!i_rst)
    o_rsp.misaligned |-> ((op_q inside {OP_H, OP_HU}) && (offset_q == 2'd3))
  ) else $error("misaligned flag on an access that is not a halfword at offset 3");

endmodule

`default_nettype wire

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  lsu_req_t   i_req,
  input  board_in_t  i_board,
  output lsu_rsp_t   o_rsp,
  output board_out_t o_board
);

  lsu_acc_t        acc;
  logic [XLEN-1:0] ram_word;
  logic [XLEN-1:0] io_word;

  lsu_access_decode i_lsu_access_decode (
    .i_req (i_req),
    .o_acc (acc)
  );

  // RAM and I/O see the same access in parallel
  lsu_data_ram i_lsu_data_ram (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_acc     (acc),
    .o_rd_word (ram_word)
  );

  lsu_board_io i_lsu_board_io (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_acc     (acc),
    .i_board   (i_board),
    .o_rd_word (io_word),
    .o_board   (o_board)
  );

  lsu_load_merge i_lsu_load_merge (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_acc      (acc),
    .i_ram_word (ram_word),
    .i_io_word  (io_word),
    .o_rsp      (o_rsp)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_lsu_checks.svh ====
`ifndef TB_LSU_CHECKS_SVH
`define TB_LSU_CHECKS_SVH

// Uses pass_cnt and fail_cnt of the including module
task automatic check_rsp(input lsu_rsp_t got, input lsu_rsp_t exp, input string what);
  if (exp.valid && !got.valid) begin
    $display("%s: no valid response in the cycle after the request (time %0t)", what, $time);
    fail_cnt++;
  end else if (got !== exp) begin
    $display("mismatch at %0t: %s valid %b data %h misaligned %b, expected %b %h %b",
             $time, what, got.valid, got.data, got.misaligned,
             exp.valid, exp.data, exp.misaligned);
    fail_cnt++;
  end else begin
    $display("ok %s: data %h misaligned %b", what, got.data, got.misaligned);
    pass_cnt++;
  end
endtask

task automatic check_board(input board_out_t got, input board_out_t exp, input string what);
  if (got.ledr !== exp.ledr || got.ledg !== exp.ledg || got.hex !== exp.hex) begin
    $display("mismatch at %0t: %s board ledr %h ledg %h hex %h, expected %h %h %h",
             $time, what, got.ledr, got.ledg, got.hex, exp.ledr, exp.ledg, exp.hex);
    fail_cnt++;
  end else begin
    $display("ok %s: board ledr %h ledg %h hex %h", what, got.ledr, got.ledg, got.hex);
    pass_cnt++;
  end
endtask

`endif

// ==== testbench/tb_lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top
  import lsu_pkg::*;
();

  typedef struct packed {
    lsu_req_t   req;
    lsu_rsp_t   exp_rsp;
    logic       chk_board;   // Compare o_board after this step
    board_out_t exp_board;
  } step_t;

  logic       i_clk;
  logic       i_rst;
  lsu_req_t   i_req;
  board_in_t  i_board;
  lsu_rsp_t   o_rsp;
  board_out_t o_board;

  int         pass_cnt = 0;
  int         fail_cnt = 0;
  logic       table_ready = 1'b0;
  step_t      steps[$];
  string      step_name[$];
  board_out_t board_model;              // Expected LED and digit state
  logic [7:0] hex_bytes [HEX_DIGITS];   // Full stored digit bytes

  `include "tb_lsu_checks.svh"

  lsu_top i_lsu_top (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   (i_req),
    .i_board (i_board),
    .o_rsp   (o_rsp),
    .o_board (o_board)
  );

  always #10 i_clk = ~i_clk;

  function automatic logic [XLEN-1:0] sign_ext8(input logic [7:0] b);
    return {{24{b[7]}}, b};
  endfunction

  function automatic logic [XLEN-1:0] sign_ext16(input logic [15:0] h);
    return {{16{h[15]}}, h};
  endfunction

  task automatic add_step(input string name, input logic we, input logic [XLEN-1:0] addr,
                          input mem_op_e op, input logic [XLEN-1:0] st_data,
                          input logic [XLEN-1:0] exp_data, input logic exp_mis,
                          input logic chk_board);
    step_t s;
    s.req.valid          = 1'b1;
    s.req.we             = we;
    s.req.addr           = addr;
    s.req.op             = op;
    s.req.st_data        = st_data;
    s.exp_rsp.valid      = 1'b1;
    s.exp_rsp.data       = exp_data;   // Zero for stores
    s.exp_rsp.misaligned = exp_mis;
    s.chk_board          = chk_board;
    s.exp_board          = board_model;
    steps.push_back(s);
    step_name.push_back(name);
  endtask

  task automatic set_hex_byte(input int idx, input logic [7:0] val);
    hex_bytes[idx]        = val;
    board_model.hex[idx]  = val[SEG_W-1:0];  // Only 7 segments driven
  endtask

  task automatic build_table();
    logic [XLEN-1:0] d0, d1, led_d, hex_d;
    logic [7:0]      b0, b1, hb;
    logic [15:0]     h, hh;
    board_model = '0;
    for (int k = 0; k < HEX_DIGITS; k++) begin
      hex_bytes[k] = 8'h00;
    end
    d0 = $urandom;
    d1 = $urandom;
    b0 = 8'($urandom) & 8'h7f;      // Positive byte
    b1 = 8'($urandom) | 8'h80;      // Negative byte
    h  = 16'($urandom) | 16'h8000;  // Negative halfword
    // Word round trip
    add_step("sw ram 0x2040", 1'b1, 32'h2040, OP_W, d0, '0, 1'b0, 1'b0);
    add_step("lw ram 0x2040", 1'b0, 32'h2040, OP_W, '0, d0, 1'b0, 1'b0);
    // Byte lanes merge into one word
    add_step("sb ram 0x2080", 1'b1, 32'h2080, OP_B, {24'($urandom), b0}, '0, 1'b0, 1'b0);
    add_step("sb ram 0x2081", 1'b1, 32'h2081, OP_B, {24'($urandom), b1}, '0, 1'b0, 1'b0);
    add_step("sh ram 0x2082", 1'b1, 32'h2082, OP_H, {16'($urandom), h}, '0, 1'b0, 1'b0);
    add_step("lw ram 0x2080", 1'b0, 32'h2080, OP_W, '0, {h, b1, b0}, 1'b0, 1'b0);
    add_step("lb ram 0x2081", 1'b0, 32'h2081, OP_B, '0, sign_ext8(b1), 1'b0, 1'b0);
    add_step("lbu ram 0x2081", 1'b0, 32'h2081, OP_BU, '0, {24'd0, b1}, 1'b0, 1'b0);
    add_step("lb ram 0x2080", 1'b0, 32'h2080, OP_B, '0, sign_ext8(b0), 1'b0, 1'b0);
    add_step("lh ram 0x2082", 1'b0, 32'h2082, OP_H, '0, sign_ext16(h), 1'b0, 1'b0);
    add_step("lhu ram 0x2082", 1'b0, 32'h2082, OP_HU, '0, {16'd0, h}, 1'b0, 1'b0);
    add_step("lh ram 0x2081", 1'b0, 32'h2081, OP_H, '0, sign_ext16({h[7:0], b1}), 1'b0, 1'b0);
    add_step("lw ram 0x2082", 1'b0, 32'h2082, OP_W, '0, {16'd0, h}, 1'b0, 1'b0);
    // Halfword at offset 3
    add_step("sw ram 0x20c0", 1'b1, 32'h20C0, OP_W, d1, '0, 1'b0, 1'b0);
    add_step("sh ram 0x20c3", 1'b1, 32'h20C3, OP_H, $urandom, '0, 1'b1, 1'b0);
    add_step("lh ram 0x20c3", 1'b0, 32'h20C3, OP_H, '0, '0, 1'b1, 1'b0);
    add_step("lhu ram 0x20c3", 1'b0, 32'h20C3, OP_HU, '0, '0, 1'b1, 1'b0);
    add_step("lw ram 0x20c0 after misaligned", 1'b0, 32'h20C0, OP_W, '0, d1, 1'b0, 1'b0);
    // LEDs truncate to their width
    led_d            = $urandom | 32'hFFFE_0000;
    board_model.ledr = led_d[LEDR_W-1:0];
    add_step("sw ledr", 1'b1, 32'h7000, OP_W, led_d, '0, 1'b0, 1'b1);
    add_step("lw ledr", 1'b0, 32'h7000, OP_W, '0, {15'd0, led_d[16:0]}, 1'b0, 1'b1);
    led_d            = $urandom;
    board_model.ledg = led_d[LEDG_W-1:0];
    add_step("sw ledg", 1'b1, 32'h7010, OP_W, led_d, '0, 1'b0, 1'b1);
    add_step("lw ledg", 1'b0, 32'h7010, OP_W, '0, {24'd0, led_d[7:0]}, 1'b0, 1'b1);
    // Digits change only where lanes are enabled
    hex_d = $urandom;
    for (int k = 0; k < 4; k++) begin
      set_hex_byte(k, hex_d[8*k +: 8]);
    end
    add_step("sw hex word0", 1'b1, 32'h7020, OP_W, hex_d, '0, 1'b0, 1'b1);
    hb = 8'($urandom);
    set_hex_byte(5, hb);
    add_step("sb hex digit5", 1'b1, 32'h7025, OP_B, {24'($urandom), hb}, '0, 1'b0, 1'b1);
    hh = 16'($urandom);
    set_hex_byte(6, hh[7:0]);
    set_hex_byte(7, hh[15:8]);
    add_step("sh hex digits 6 and 7", 1'b1, 32'h7026, OP_H, {16'($urandom), hh}, '0, 1'b0,
             1'b1);
    hb = 8'($urandom);
    set_hex_byte(1, hb);
    add_step("sb hex digit1", 1'b1, 32'h7021, OP_B, {24'($urandom), hb}, '0, 1'b0, 1'b1);
    add_step("lw hex word1", 1'b0, 32'h7024, OP_W, '0,
             {hex_bytes[7], hex_bytes[6], hex_bytes[5], hex_bytes[4]}, 1'b0, 1'b1);
    add_step("lw hex word0", 1'b0, 32'h7020, OP_W, '0,
             {hex_bytes[3], hex_bytes[2], hex_bytes[1], hex_bytes[0]}, 1'b0, 1'b1);
    add_step("lbu hex digit1", 1'b0, 32'h7021, OP_BU, '0, {24'd0, hex_bytes[1]}, 1'b0, 1'b1);
    // Inputs and the unmapped space
    add_step("lw switches", 1'b0, 32'h7800, OP_W, '0, {14'd0, i_board.sw}, 1'b0, 1'b1);
    add_step("lbu switches byte1", 1'b0, 32'h7801, OP_BU, '0, {24'd0, i_board.sw[15:8]},
             1'b0, 1'b0);
    add_step("lw buttons", 1'b0, 32'h7810, OP_W, '0, {22'd0, i_board.btn}, 1'b0, 1'b0);
    add_step("lw unmapped", 1'b0, 32'h5000, OP_W, '0, '0, 1'b0, 1'b0);
    // 0x4040 shares its low word index with 0x2040
    add_step("sw unmapped", 1'b1, 32'h4040, OP_W, $urandom, '0, 1'b0, 1'b1);
    add_step("lw unmapped after store", 1'b0, 32'h4040, OP_W, '0, '0, 1'b0, 1'b1);
    add_step("lw ram 0x2040 again", 1'b0, 32'h2040, OP_W, '0, d0, 1'b0, 1'b1);
  endtask

  initial begin
    void'($urandom(64084));
    i_clk       = 1'b0;
    i_rst       = 1'b0;
    i_req       = '0;
    i_board.sw  = 18'($urandom);
    i_board.btn = 10'($urandom);
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge i_clk);
    i_rst <= 1'b1;
    @(negedge i_clk);
    check_rsp(o_rsp, '0, "idle after reset");
    check_board(o_board, '0, "board after reset");
    foreach (steps[i]) begin
      @(posedge i_clk);
      i_req <= steps[i].req;
      @(posedge i_clk);          // DUT captures the request here
      i_req <= '0;
      @(negedge i_clk);          // Response of that edge is stable
      check_rsp(o_rsp, steps[i].exp_rsp, step_name[i]);
      if (steps[i].chk_board) begin
        check_board(o_board, steps[i].exp_board, step_name[i]);
      end
    end
    @(posedge i_clk);
    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Three clock periods per table entry, plus margin
  initial begin
    wait (table_ready);
    #((steps.size() + 10) * 3 * 20);
    $display("timeout: the test sequence did not finish in time (%0t)", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+testbench
rtl/lsu_pkg.sv
rtl/lsu_access_decode.sv
rtl/lsu_data_ram.sv
rtl/lsu_board_io.sv
rtl/lsu_load_merge.sv
rtl/lsu_top.sv
testbench/tb_lsu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the LSU testbench with Verilator, run it and scan the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module tb_lsu_top \
  -o tb_lsu_top

./obj_dir/tb_lsu_top 2>&1 | tee "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi

echo "simulation finished without failure"
